// File: verilog/ifetch_pkg.sv
// Widths, encodings and bus structs shared by the fetch front end and its testbench.
// Byte addresses are 32 bits wide. Lines are 32 bytes, so offset_bits and line_bits go together.
package ifetch_pkg;

    localparam int line_bits   = 256;  // One cache line.
    localparam int offset_bits = 5;    // Byte offset inside a line.
    localparam int index_bits  = 3;    // Direct-mapped set index.
    localparam int num_lines   = 8;    // 2**index_bits.
    localparam int tag_bits    = 24;   // 32 - index_bits - offset_bits.
    localparam int pf_entries  = 2;    // Prefetch buffer depth.

    // Instruction cache FSM.
    typedef enum logic [2:0] {
        idle,      // Waiting for an APB access phase.
        lookup,    // Miss, probing the prefetch buffer.
        pf_take,   // Copying the buffered line in.
        mem_fill,  // Waiting on pmem.
        respond    // pready cycle.
    } icache_state_t;

    // Owner of the pmem port.
    typedef enum logic [1:0] {
        grant_none,
        grant_demand,
        grant_prefetch
    } arb_grant_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;   // Always answered with pslverr.
        logic [31:0] paddr;
    } apb_req_t;  // 35 bits.

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;  // 34 bits.

    typedef struct packed {
        logic        read;
        logic [31:0] addr;     // Line aligned.
    } pmem_req_t;  // 33 bits.

    typedef struct packed {
        logic                 resp;
        logic [line_bits-1:0] rdata;  // Valid only with resp.
    } pmem_rsp_t;  // 257 bits.

endpackage

// File: verilog/prefetch_buffer.sv
`timescale 1ns/10ps
// Two-entry fully associative line buffer. Compares ignore the byte offset of mem_addr.
// The victim pointer is one bit, so pf_entries must stay 2.
module prefetch_buffer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [31:0]                      mem_addr,     // Demand or prefetch address.
    input  logic                             pf_read,      // Demand side probing.
    input  logic                             pf_write,     // Prefetch side owns the port.
    input  logic                             pf_ld,        // Pmem answered, capture line.
    input  logic [ifetch_pkg::line_bits-1:0] mem_rdata,
    output logic                             pf_hit,
    output logic                             pf_miss,
    output logic [ifetch_pkg::line_bits-1:0] pf_mem_rdata
);

    logic [ifetch_pkg::pf_entries-1:0]      valid;
    logic [31-ifetch_pkg::offset_bits:0]    line_tag  [ifetch_pkg::pf_entries];
    logic [ifetch_pkg::line_bits-1:0]       line_data [ifetch_pkg::pf_entries];
    logic                                   victim;   // Least recently used entry.
    logic                                   hit_num;
    logic [31-ifetch_pkg::offset_bits:0]    req_tag;
    logic                                   load;

    assign req_tag = mem_addr[31:ifetch_pkg::offset_bits];  // Line number only.

    // An entry matches only while valid, so a cleared entry never hits line 0.
    always_comb begin
        pf_hit  = 1'b0;
        hit_num = 1'b0;
        for (int i = 0; i < ifetch_pkg::pf_entries; i++) begin
            if (valid[i] && (line_tag[i] == req_tag)) begin
                pf_hit  = 1'b1;
                hit_num = i[0];
            end
        end
    end

    assign pf_miss      = !pf_hit;
    assign pf_mem_rdata = line_data[hit_num];  // Don't care on a miss.

    // Fill only a missing line, and only while the prefetcher owns pmem.
    assign load = pf_write && pf_ld && pf_miss;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid  <= '0;
            victim <= 1'b0;
        end else if (load) begin
            valid[victim] <= 1'b1;
            victim        <= !victim;  // New line is now most recent.
        end else if (pf_hit && (pf_read || pf_write)) begin
            victim <= !hit_num;        // Touched entry survives.
        end
    end

    // Tag and line storage.
    always_ff @(posedge clk) begin
        if (load) begin
            line_tag[victim]  <= req_tag;
            line_data[victim] <= mem_rdata;
        end
    end

    // A duplicate would make pf_mem_rdata depend on entry order.
    a_no_dup_line: assert property (@(posedge clk) disable iff (rst)
        (&valid) |-> (line_tag[0] != line_tag[1]))
        else $error("prefetch_buffer: both entries hold line %h", line_tag[0]);

endmodule

// File: verilog/next_line_prefetcher.sv
`timescale 1ns/10ps
// One outstanding next-line prefetch at a time. A fill_done during a pending
// prefetch is dropped. Lines past the top of the address space are not fetched.
module next_line_prefetcher (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fill_done,   // Cache just installed a line.
    input  logic [31:0]           fill_addr,   // Line address of that fill.
    input  logic                  pf_hit,      // Buffer result for the target line.
    output ifetch_pkg::pmem_req_t pf_req,
    input  ifetch_pkg::pmem_rsp_t pf_rsp
);

    logic        pending;  // A prefetch is owed or in flight.
    logic        check;    // First pending cycle probes the buffer.
    logic [31:0] target;
    logic        wraps;
    logic        cancel;

    // Last line of memory has no successor.
    assign wraps = &fill_addr[31:ifetch_pkg::offset_bits];

    // The buffer already has the line, so no pmem request is raised.
    assign cancel = check && pf_hit;

    always_comb begin
        pf_req.read = pending && !cancel;
        pf_req.addr = target;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            check   <= 1'b0;
        end else begin
            check <= 1'b0;  // Probe lasts one cycle.
            if (!pending) begin
                if (fill_done && !wraps) begin
                    pending <= 1'b1;
                    check   <= 1'b1;
                end
            end else if (cancel || pf_rsp.resp) begin
                pending <= 1'b0;  // Done, or not needed.
            end
        end
    end

    // Next line address, captured only when idle.
    always_ff @(posedge clk) begin
        if (!pending && fill_done) begin
            target <= {fill_addr[31:ifetch_pkg::offset_bits] + 1'b1,
                       {ifetch_pkg::offset_bits{1'b0}}};
        end
    end

    // Address and read are held until the response, as pmem requires.
    a_pf_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (pf_req.read && !pf_rsp.resp) |=> (pf_req.read && $stable(pf_req.addr)))
        else $error("next_line_prefetcher: request changed before resp");

endmodule

// File: verilog/pmem_arbiter.sv
`timescale 1ns/10ps
// Shares the single pmem port between cache fills and prefetches. Demand wins only
// at an idle port. A prefetch that returns during a buffer lookup is not kept.
module pmem_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  ifetch_pkg::pmem_req_t dem_req,
    input  logic [31:0]           dem_addr_lookup,  // Line the cache is probing.
    input  logic                  lookup,
    input  ifetch_pkg::pmem_req_t pf_req,
    output ifetch_pkg::pmem_rsp_t dem_rsp,
    output ifetch_pkg::pmem_rsp_t pf_rsp,
    output ifetch_pkg::pmem_req_t pmem_req,
    input  ifetch_pkg::pmem_rsp_t pmem_rsp,
    output logic [31:0]           buf_addr,
    output logic                  buf_read,
    output logic                  buf_write,
    output logic                  buf_ld
);

    ifetch_pkg::arb_grant_t grant_q;  // Held owner.
    ifetch_pkg::arb_grant_t grant;    // Owner this cycle.

    // A held grant stands until resp, else pick demand first.
    always_comb begin
        if (grant_q != ifetch_pkg::grant_none) begin
            grant = grant_q;
        end else if (dem_req.read) begin
            grant = ifetch_pkg::grant_demand;
        end else if (pf_req.read) begin
            grant = ifetch_pkg::grant_prefetch;
        end else begin
            grant = ifetch_pkg::grant_none;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant_q <= ifetch_pkg::grant_none;
        end else if (pmem_rsp.resp) begin
            grant_q <= ifetch_pkg::grant_none;  // Transfer over.
        end else begin
            grant_q <= grant;
        end
    end

    // Route the port.
    always_comb begin
        case (grant)
            ifetch_pkg::grant_demand:   pmem_req = dem_req;
            ifetch_pkg::grant_prefetch: pmem_req = pf_req;
            default:                    pmem_req = '0;
        endcase
        dem_rsp.resp  = pmem_rsp.resp && (grant == ifetch_pkg::grant_demand);
        dem_rsp.rdata = pmem_rsp.rdata;
        pf_rsp.resp   = pmem_rsp.resp && (grant == ifetch_pkg::grant_prefetch);
        pf_rsp.rdata  = pmem_rsp.rdata;
    end

    // Buffer port. A lookup keeps the address, so a load then is skipped.
    assign buf_addr  = lookup ? dem_addr_lookup : pf_req.addr;
    assign buf_read  = lookup;
    assign buf_write = (grant == ifetch_pkg::grant_prefetch) && !lookup;
    assign buf_ld    = buf_write && pmem_rsp.resp;

    a_pmem_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (pmem_req.read && !pmem_rsp.resp) |=> $stable(pmem_req.addr))
        else $error("pmem_arbiter: pmem addr moved during a read");

    // A response reaches exactly the one side that is asking.
    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        pmem_rsp.resp |-> ((dem_rsp.resp && dem_req.read) ^ (pf_rsp.resp && pf_req.read)))
        else $error("pmem_arbiter: response without a single granted requester");

endmodule

// File: verilog/icache.sv
`timescale 1ns/10ps
// Read-only direct-mapped instruction cache on an APB slave port, 8 lines of 32 bytes.
// Writes and misaligned reads get pslverr. Every transfer takes at least one wait state.
module icache (
    input  logic                             clk,
    input  logic                             rst,
    input  ifetch_pkg::apb_req_t             apb_req,
    output ifetch_pkg::apb_rsp_t             apb_rsp,
    output logic                             lookup,        // Buffer probe in progress.
    output logic [31:0]                      lookup_addr,
    input  logic                             pf_hit,
    input  logic [ifetch_pkg::line_bits-1:0] pf_mem_rdata,
    output ifetch_pkg::pmem_req_t            dem_req,
    input  ifetch_pkg::pmem_rsp_t            dem_rsp,
    output logic                             fill_done,     // One pulse per install.
    output logic [31:0]                      fill_addr
);

    ifetch_pkg::icache_state_t state;

    logic [ifetch_pkg::tag_bits-1:0]   tag_arr  [ifetch_pkg::num_lines];
    logic [ifetch_pkg::line_bits-1:0]  data_arr [ifetch_pkg::num_lines];
    logic [ifetch_pkg::num_lines-1:0]  valid_arr;

    logic [31:0] addr_q;   // Address of the transfer in service.
    logic [31:0] rdata_q;
    logic        err_q;

    logic                                 access;
    logic                                 bad_req;
    logic                                 hit;
    logic [ifetch_pkg::index_bits-1:0]    req_idx;
    logic [ifetch_pkg::index_bits-1:0]    fill_idx;
    logic [ifetch_pkg::tag_bits-1:0]      req_tag;
    logic [ifetch_pkg::offset_bits-3:0]   req_word;
    logic [ifetch_pkg::offset_bits-3:0]   fill_word;
    logic                                 install;
    logic [ifetch_pkg::line_bits-1:0]     install_line;

    // First access cycle of a transfer.
    assign access  = apb_req.psel && apb_req.penable && (state == ifetch_pkg::idle);
    assign bad_req = apb_req.pwrite || (apb_req.paddr[1:0] != 2'b00);

    assign req_idx  = apb_req.paddr[ifetch_pkg::offset_bits +: ifetch_pkg::index_bits];
    assign req_tag  = apb_req.paddr[31 -: ifetch_pkg::tag_bits];
    assign req_word = apb_req.paddr[ifetch_pkg::offset_bits-1:2];
    assign hit      = valid_arr[req_idx] && (tag_arr[req_idx] == req_tag);

    assign fill_idx  = addr_q[ifetch_pkg::offset_bits +: ifetch_pkg::index_bits];
    assign fill_word = addr_q[ifetch_pkg::offset_bits-1:2];

    // Line comes from the buffer in pf_take, from pmem otherwise.
    assign install      = (state == ifetch_pkg::pf_take) ||
                          ((state == ifetch_pkg::mem_fill) && dem_rsp.resp);
    assign install_line = (state == ifetch_pkg::pf_take) ? pf_mem_rdata : dem_rsp.rdata;

    assign lookup_addr = {addr_q[31:ifetch_pkg::offset_bits], {ifetch_pkg::offset_bits{1'b0}}};
    // The buffer must keep pointing at our line until it is copied.
    assign lookup = (state == ifetch_pkg::lookup) || (state == ifetch_pkg::pf_take);

    always_comb begin
        dem_req.read = (state == ifetch_pkg::mem_fill);  // Drops after resp.
        dem_req.addr = lookup_addr;
    end

    assign fill_done = install;
    assign fill_addr = lookup_addr;

    always_comb begin
        apb_rsp.pready  = (state == ifetch_pkg::respond);
        apb_rsp.pslverr = (state == ifetch_pkg::respond) && err_q;
        apb_rsp.prdata  = rdata_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ifetch_pkg::idle;
            err_q     <= 1'b0;
            valid_arr <= '0;
        end else begin
            case (state)
                ifetch_pkg::idle: begin
                    if (access) begin
                        err_q <= bad_req;
                        state <= (bad_req || hit) ? ifetch_pkg::respond : ifetch_pkg::lookup;
                    end
                end
                ifetch_pkg::lookup:   state <= pf_hit ? ifetch_pkg::pf_take : ifetch_pkg::mem_fill;
                ifetch_pkg::pf_take:  state <= ifetch_pkg::respond;
                ifetch_pkg::mem_fill: if (dem_rsp.resp) state <= ifetch_pkg::respond;
                default:              state <= ifetch_pkg::idle;  // respond lasts one cycle.
            endcase
            if (install) begin
                valid_arr[fill_idx] <= 1'b1;
            end
        end
    end

    // Arrays and read data.
    always_ff @(posedge clk) begin
        if (access) begin
            addr_q  <= apb_req.paddr;
            rdata_q <= bad_req ? 32'd0 : data_arr[req_idx][{req_word, 5'd0} +: 32];
        end
        if (install) begin
            tag_arr[fill_idx]  <= addr_q[31 -: ifetch_pkg::tag_bits];
            data_arr[fill_idx] <= install_line;
            rdata_q            <= install_line[{fill_word, 5'd0} +: 32];
        end
    end

    // Never answer outside an access phase of the master.
    a_pready_in_access: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
        else $error("icache: pready outside an APB access phase");

endmodule

// File: verilog/ifetch_top.sv
`timescale 1ns/10ps
// Fetch front end. Pmem lies outside and must follow the hold-until-resp rule.
module ifetch_top (
    input  logic                  clk,
    input  logic                  rst,
    input  ifetch_pkg::apb_req_t  apb_req,
    output ifetch_pkg::apb_rsp_t  apb_rsp,
    output ifetch_pkg::pmem_req_t pmem_req,
    input  ifetch_pkg::pmem_rsp_t pmem_rsp
);

    ifetch_pkg::pmem_req_t            dem_req;
    ifetch_pkg::pmem_rsp_t            dem_rsp;
    ifetch_pkg::pmem_req_t            pf_req;
    ifetch_pkg::pmem_rsp_t            pf_rsp;
    logic                             lookup;
    logic [31:0]                      lookup_addr;
    logic                             fill_done;
    logic [31:0]                      fill_addr;
    logic [31:0]                      buf_addr;
    logic                             buf_read;
    logic                             buf_write;
    logic                             buf_ld;
    logic                             pf_hit;
    logic [ifetch_pkg::line_bits-1:0] pf_mem_rdata;

    icache icache_i (
        .clk, .rst, .apb_req, .apb_rsp, .lookup, .lookup_addr, .pf_hit,
        .pf_mem_rdata, .dem_req, .dem_rsp, .fill_done, .fill_addr
    );

    next_line_prefetcher prefetcher_i (
        .clk, .rst, .fill_done, .fill_addr, .pf_hit, .pf_req, .pf_rsp
    );

    // Only pf_hit is consumed; pf_miss is its complement.
    prefetch_buffer buffer_i (
        .clk, .rst, .mem_addr(buf_addr), .pf_read(buf_read), .pf_write(buf_write),
        .pf_ld(buf_ld), .mem_rdata(pf_rsp.rdata), .pf_hit, .pf_miss(),
        .pf_mem_rdata
    );

    pmem_arbiter arbiter_i (
        .clk, .rst, .dem_req, .dem_addr_lookup(lookup_addr), .lookup, .pf_req,
        .dem_rsp, .pf_rsp, .pmem_req, .pmem_rsp, .buf_addr, .buf_read, .buf_write,
        .buf_ld
    );

endmodule

// File: test/tb_checker.sv
`timescale 1ns/10ps
// Watches ifetch_top ports and compares each finished APB transfer with exp_word.
// Assumes one transfer at a time, named through start_test.
module tb_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  ifetch_pkg::apb_req_t  apb_req,
    input  ifetch_pkg::apb_rsp_t  apb_rsp,
    input  ifetch_pkg::pmem_req_t pmem_req,
    input  ifetch_pkg::pmem_rsp_t pmem_rsp,
    input  logic [31:0]           exp_word,     // Reference word for paddr.
    output int                    error_count
);

    string test_name    = "none";
    logic  watch_line   = 1'b0;  // Pmem must not serve the transfer's own line.
    logic  seen_access  = 1'b0;
    int    test_checks  = 0;
    int    test_errors  = 0;
    int    tests_done   = 0;
    int    total_checks = 0;
    int    errors       = 0;

    assign error_count = errors;

    task automatic note_error(input string what);
        $display("error in %s at %0t: %s", test_name, $time, what);
        test_errors++;
        errors++;
    endtask

    task automatic compare_transfer();
        logic exp_err;
        exp_err = apb_req.pwrite || (apb_req.paddr[1:0] != 2'b00);  // Write or misaligned.
        test_checks++;
        total_checks++;
        if (apb_rsp.pslverr !== exp_err) begin
            $display("mismatch %s pslverr @%h: expected %b, actual %b",
                     test_name, apb_req.paddr, exp_err, apb_rsp.pslverr);
            test_errors++;
            errors++;
        end else if (!exp_err && (apb_rsp.prdata !== exp_word)) begin
            $display("mismatch %s prdata @%h: expected %h, actual %h",
                     test_name, apb_req.paddr, exp_word, apb_rsp.prdata);
            test_errors++;
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (!seen_access && (apb_rsp.pready || apb_rsp.pslverr || pmem_req.read)) begin
                note_error("pready, pslverr or pmem read active before the first access");
            end
            if (apb_req.psel && apb_req.penable) begin
                seen_access = 1'b1;
            end
            if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
                compare_transfer();
            end
            if (watch_line && apb_req.psel && pmem_req.read && pmem_rsp.resp &&
                (pmem_req.addr[31:5] == apb_req.paddr[31:5])) begin
                note_error("pmem served a read of the line this transfer asks for");
            end
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        watch_line  = 1'b0;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic watch_refetch(input logic on);
        watch_line = on;
    endtask

    task automatic end_test();
        tests_done++;
        $display("test %s: %0d transfers, %0d errors, %s", test_name, test_checks,
                 test_errors, (test_errors == 0) ? "ok" : "failed");
    endtask

    task automatic print_totals();
        $display("totals: %0d tests, %0d transfers checked, %0d errors",
                 tests_done, total_checks, errors);
    endtask

endmodule

// File: test/tb_top.sv
`timescale 1ns/10ps
// Testbench for ifetch_top. Pmem answers each line read after pmem_latency cycles.
// Random reads stay in a 4 KB window, so both hits and index conflicts occur.
module tb_top;

    localparam int          pmem_latency   = 4;
    localparam int          num_random     = 200;
    localparam logic [31:0] seed           = 32'd99;
    localparam int          gap_cycles     = 2 * pmem_latency + 4;  // Lets a prefetch land.
    localparam int          num_transfers  = 1 + 8 + 2 + 4 + 8 + num_random;
    localparam int          worst_cycles   = 2 * pmem_latency + 8;  // Prefetch ahead plus own fill.
    localparam int          timeout_cycles = (num_transfers * worst_cycles + gap_cycles + 20) * 2;

    logic                  clk;
    logic                  rst;
    ifetch_pkg::apb_req_t  apb_req;
    ifetch_pkg::apb_rsp_t  apb_rsp;
    ifetch_pkg::pmem_req_t pmem_req;
    ifetch_pkg::pmem_rsp_t pmem_rsp;
    logic [31:0]           exp_word;     // Reference word at the current paddr.
    int                    error_count;
    logic [31:0]           lcg_state;
    logic [31:0]           served [$];   // Line addresses pmem has answered.

    ifetch_top dut_i (.clk, .rst, .apb_req, .apb_rsp, .pmem_req, .pmem_rsp);

    tb_checker chk_i (
        .clk, .rst, .apb_req, .apb_rsp, .pmem_req, .pmem_rsp, .exp_word, .error_count
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Each word is a fixed hash of its own word address.
    function automatic logic [31:0] word_ref(input logic [31:0] addr);
        logic [31:0] x;
        x = lcg_next({addr[31:2], 2'b00} ^ 32'h3c5a_96e1);
        return x ^ (x >> 13);
    endfunction

    // Word i of a line sits at bits 32*i, the word with byte offset 4*i.
    function automatic logic [ifetch_pkg::line_bits-1:0] line_data(input logic [31:0] addr);
        logic [ifetch_pkg::line_bits-1:0] line;
        for (int i = 0; i < 8; i++) begin
            line[32*i +: 32] = word_ref({addr[31:5], 5'd0} + 32'(4 * i));
        end
        return line;
    endfunction

    assign exp_word = word_ref(apb_req.paddr);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Pmem model. One read at a time, resp on the pmem_latency-th falling edge.
    initial begin : pmem_model
        int wait_cnt;
        pmem_rsp = '0;
        wait_cnt = 0;
        forever begin
            @(negedge clk);
            if (rst || pmem_rsp.resp || !pmem_req.read) begin
                pmem_rsp.resp = 1'b0;  // Read drops after resp.
                wait_cnt      = 0;
            end else if (wait_cnt == pmem_latency - 1) begin
                pmem_rsp.rdata = line_data(pmem_req.addr);
                pmem_rsp.resp  = 1'b1;
                served.push_back(pmem_req.addr);
            end else begin
                wait_cnt++;
            end
        end
    end

    // Setup phase, then access phase held until pready.
    task automatic apb_transfer(input logic [31:0] addr, input logic write);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        @(negedge clk);
        apb_req.penable = 1'b1;
        do begin
            @(negedge clk);
        end while (!apb_rsp.pready);
        @(negedge clk);  // Transfer ended on the edge before.
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    initial begin
        logic [31:0] addr_a;
        apb_req   = '0;
        rst       = 1'b1;
        lcg_state = seed;
        addr_a    = 32'h0000_1040;
        chk_i.start_test("cold_read");
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);  // Idle outputs watched by the checker.
        apb_transfer(addr_a + 32'd8, 1'b0);
        chk_i.end_test();
        chk_i.start_test("line_reread");
        chk_i.watch_refetch(1'b1);
        for (int w = 0; w < 8; w++) begin
            apb_transfer(addr_a + 32'(4 * w), 1'b0);
        end
        chk_i.end_test();
        chk_i.start_test("next_line_prefetch");
        apb_transfer(32'h0000_2004, 1'b0);
        repeat (gap_cycles) @(negedge clk);
        chk_i.watch_refetch(1'b1);  // Line 0x2020 must come from the buffer.
        apb_transfer(32'h0000_202c, 1'b0);
        chk_i.end_test();
        chk_i.start_test("error_responses");
        apb_transfer(addr_a, 1'b1);
        apb_transfer(addr_a + 32'd4, 1'b0);
        apb_transfer(32'h0000_3001, 1'b0);
        apb_transfer(32'h0000_3000, 1'b0);
        chk_i.end_test();
        chk_i.start_test("index_conflict");
        for (int r = 0; r < 4; r++) begin
            apb_transfer(32'h0000_4084, 1'b0);
            apb_transfer(32'h0000_4184, 1'b0);  // Same index, other tag.
        end
        chk_i.end_test();
        chk_i.start_test("random_reads");
        for (int n = 0; n < num_random; n++) begin
            lcg_state = lcg_next(lcg_state);
            apb_transfer(32'h0000_8000 | {20'd0, lcg_state[29:20], 2'b00}, 1'b0);
        end
        chk_i.end_test();
        $display("pmem served %0d line reads", served.size());
        chk_i.print_totals();
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: run did not finish in %0d cycles, a transfer hung", timeout_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: compile.f
verilog/ifetch_pkg.sv
verilog/prefetch_buffer.sv
verilog/next_line_prefetcher.sv
verilog/pmem_arbiter.sv
verilog/icache.sv
verilog/ifetch_top.sv
test/tb_checker.sv
test/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the fetch front end testbench with Verilator.
cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
        -Mdir obj_dir -f compile.f; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_top)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF '*** PASSED ***' <<< "$output"; then
    exit 0
fi
exit 1
